// File: Makefile
# Verilator build and run of the video overlay testbench

TOP := video_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		-f sim.f --top-module $(TOP) -o V$(TOP)

# the simulation output is searched for the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f sim.f --top-module video_overlay_top

clean:
	rm -rf obj_dir

// File: dv/video_tb.sv
/*
 * testbench for the video overlay top level
 * clock, reset, wishbone master tasks and random stimulus
 * pixel and sync model with compare tasks, watchdog
 */
`default_nettype none

module video_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import video_pkg::*;

    // ----------------------------------------
    // raster and run constants
    // ----------------------------------------

    localparam int   CLK_PERIOD   = 20;
    localparam int   H_DISPLAY    = 64;
    localparam int   H_FRONT      = 4;
    localparam int   H_SYNC       = 8;
    localparam int   H_BACK       = 4;
    localparam int   V_DISPLAY    = 48;
    localparam int   V_FRONT      = 2;
    localparam int   V_SYNC       = 2;
    localparam int   V_BACK       = 2;
    localparam int   H_TOTAL      = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
    localparam int   V_TOTAL      = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
    localparam int   FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int   SPR_W        = 16;
    localparam int   SPR_H        = 16;
    localparam rgb_t KEY_COLOR    = '0;
    // sync gen, bar gen and sprite gen each add one register
    localparam int   PIPE_DEPTH   = 3;
    localparam int   ACK_LIMIT    = 8;
    // 4 patterns, 3 placed sprites, 4 clipped sprites, 1 disabled frame
    localparam int   FRAMES_TESTED = 12;
    localparam int   FRAME_MARGIN  = 4;
    localparam int   WATCHDOG_NS   = (FRAMES_TESTED + FRAME_MARGIN) * FRAME_CYCLES * CLK_PERIOD;

    logic     clk = 1'b0;
    logic     rst_n = 1'b0;
    logic     wb_cyc = 1'b0;
    logic     wb_stb = 1'b0;
    logic     wb_we = 1'b0;
    wb_addr_t wb_adr = '0;
    wb_data_t wb_dat_i = '0;
    wb_data_t wb_dat_o;
    logic     wb_ack;
    logic     hsync;
    logic     vsync;
    rgb_t     rgb;

    integer   seed;
    logic     pix_check = 1'b0;
    int       out_idx = 0;

    // shadow of the register file and the sprite memory
    wb_data_t sh_x0 = '0;
    wb_data_t sh_y0 = '0;
    logic     sh_en = 1'b0;
    pattern_e sh_pat = PAT_SOLID;
    rgb_t     sh_bg = '0;
    logic [7:0] sh_ld = '0;
    rgb_t     sh_spr [SPR_W * SPR_H];

    always #(CLK_PERIOD / 2) clk = ~clk;

    video_overlay_top #(
        .H_DISPLAY     (H_DISPLAY),
        .H_FRONT       (H_FRONT),
        .H_SYNC        (H_SYNC),
        .H_BACK        (H_BACK),
        .V_DISPLAY     (V_DISPLAY),
        .V_FRONT       (V_FRONT),
        .V_SYNC        (V_SYNC),
        .V_BACK        (V_BACK),
        .SPRITE_HSIZE  (SPR_W),
        .SPRITE_VSIZE  (SPR_H),
        .SPRITE_RAM_AW (8),
        .KEY_COLOR     (KEY_COLOR)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .hsync    (hsync),
        .vsync    (vsync),
        .rgb      (rgb)
    );

    // ----------------------------------------
    // failure handling and compare tasks
    // ----------------------------------------

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input int x, input int y);
        if (got !== exp) begin
            $display("ERROR @ %0t: rgb at x=%0d y=%0d is %h, expected %h", $time, x, y, got, exp);
            abort_run();
        end
    endtask

    task automatic check_wb_data(input wb_data_t got, input wb_data_t exp, input wb_addr_t adr);
        if (got !== exp) begin
            $display("ERROR @ %0t: register %0d read %h, expected %h", $time, adr, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sync(input logic hs, input logic vs, input logic exp_hs,
                              input logic exp_vs, input int x, input int y);
        if (hs !== exp_hs || vs !== exp_vs) begin
            $display("ERROR @ %0t: syncs at x=%0d y=%0d are %b/%b, expected %b/%b",
                     $time, x, y, hs, vs, exp_hs, exp_vs);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // register and pixel model
    // ----------------------------------------

    // value a register returns after a write of v
    function automatic wb_data_t read_mask(input reg_sel_e sel, input wb_data_t v);
        case (sel)
            REG_X0:       return v;
            REG_Y0:       return v;
            REG_CTRL:     return v & 16'h0007;
            REG_BG:       return v & 16'h0fff;
            REG_RAM_ADDR: return v & 16'h00ff;
            default:      return '0;
        endcase
    endfunction

    // applied at a rising edge, the model samples on falling edges
    task automatic apply_write(input reg_sel_e sel, input wb_data_t d);
        case (sel)
            REG_X0:       sh_x0 = d;
            REG_Y0:       sh_y0 = d;
            REG_CTRL: begin
                sh_en  = d[0];
                sh_pat = pattern_e'(d[2:1]);
            end
            REG_BG:       sh_bg = rgb_t'(d[11:0]);
            REG_RAM_ADDR: sh_ld = d[7:0];
            REG_RAM_DATA: begin
                sh_spr[sh_ld] = rgb_t'(d[11:0]);
                sh_ld = sh_ld + 8'd1;
            end
            default:      ;
        endcase
    endtask

    function automatic rgb_t expect_pixel(input int x, input int y);
        rgb_t       bg;
        rgb_t       spr;
        int         dx;
        int         dy;
        logic [3:0] lvl;
        if (x >= H_DISPLAY || y >= V_DISPLAY) begin
            return '0;
        end
        case (sh_pat)
            PAT_SOLID: bg = sh_bg;
            PAT_HBARS: begin
                lvl = 4'(y >> 2);
                bg = rgb_t'({lvl, lvl, lvl});
            end
            PAT_VBARS: begin
                lvl = 4'(x >> 2);
                bg = rgb_t'({lvl, lvl, lvl});
            end
            default: bg = ((((x >> 3) ^ (y >> 3)) & 1) != 0) ? rgb_t'(12'hfff) : rgb_t'(12'h000);
        endcase
        // origin is a signed 16-bit value
        dx = x - int'($signed(sh_x0));
        dy = y - int'($signed(sh_y0));
        if (sh_en && dx >= 0 && dx < SPR_W && dy >= 0 && dy < SPR_H) begin
            spr = sh_spr[dy * SPR_W + dx];
            if (spr != KEY_COLOR) begin
                return spr;
            end
        end
        return bg;
    endfunction

    // output at falling edge k after reset shows the counter value of cycle k-3
    always @(negedge clk) begin : pixel_model
        int   p;
        int   x;
        int   y;
        logic exp_hs;
        logic exp_vs;
        rgb_t exp_rgb;
        if (!rst_n) begin
            out_idx = 0;
            if (wb_ack !== 1'b0) begin
                $display("ERROR @ %0t: wb_ack is high during reset", $time);
                abort_run();
            end
            check_sync(hsync, vsync, 1'b1, 1'b1, -1, -1);
            check_rgb(rgb, rgb_t'(0), -1, -1);
        end else begin
            x = -1;
            y = -1;
            exp_hs = 1'b1;
            exp_vs = 1'b1;
            exp_rgb = '0;
            if (out_idx >= PIPE_DEPTH) begin
                p = (out_idx - PIPE_DEPTH) % FRAME_CYCLES;
                x = p % H_TOTAL;
                y = p / H_TOTAL;
                exp_hs = !(x >= H_DISPLAY + H_FRONT && x <= H_DISPLAY + H_FRONT + H_SYNC - 1);
                exp_vs = !(y >= V_DISPLAY + V_FRONT && y <= V_DISPLAY + V_FRONT + V_SYNC - 1);
                exp_rgb = expect_pixel(x, y);
            end
            check_sync(hsync, vsync, exp_hs, exp_vs, x, y);
            if (pix_check || out_idx < PIPE_DEPTH) begin
                check_rgb(rgb, exp_rgb, x, y);
            end
            out_idx++;
        end
    end

    // ----------------------------------------
    // wishbone master
    // ----------------------------------------

    // request held until ack, ack must last exactly one cycle
    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t din,
                             output wb_data_t dout);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= din;
        @(negedge clk);
        while (wb_ack !== 1'b1) begin
            wait_cnt++;
            if (wait_cnt > ACK_LIMIT) begin
                $display("no wb_ack within %0d cycles for register %0d", ACK_LIMIT, adr);
                abort_run();
            end
            @(negedge clk);
        end
        if (wait_cnt != 1) begin
            $display("wb_ack came %0d cycles after the request instead of one", wait_cnt);
            abort_run();
        end
        dout = wb_dat_o;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (we) begin
            apply_write(reg_sel_e'(adr), din);
        end
        @(negedge clk);
        if (wb_ack !== 1'b0) begin
            $display("wb_ack stayed high for more than one cycle on register %0d", adr);
            abort_run();
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t d);
        wb_data_t unused;
        wb_access(1'b1, adr, d, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t d);
        wb_access(1'b0, adr, '0, d);
    endtask

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic wait_vblank();
        do begin
            @(negedge clk);
        end while (vsync !== 1'b0);
    endtask

    // one whole output frame from the end of vsync to the next vsync
    task automatic run_frame();
        do begin
            @(negedge clk);
        end while (vsync !== 1'b1);
        wait_vblank();
    endtask

    // about a quarter of the pixels are transparent
    task automatic load_sprite();
        rgb_t px;
        int   i;
        wb_write(REG_RAM_ADDR, '0);
        for (i = 0; i < SPR_W * SPR_H; i++) begin
            if (rand_below(4) == 0) begin
                px = KEY_COLOR;
            end else begin
                px = rgb_t'(12'($random(seed)));
            end
            wb_write(REG_RAM_DATA, {4'b0, px});
        end
    endtask

    // registers change only while vsync is low
    task automatic frame_step(input int ox, input int oy, input logic en,
                              input pattern_e pat, input rgb_t bg);
        wait_vblank();
        wb_write(REG_X0, wb_data_t'(ox));
        wb_write(REG_Y0, wb_data_t'(oy));
        wb_write(REG_BG, {4'b0, bg});
        wb_write(REG_CTRL, {13'b0, pat, en});
        @(posedge clk);
        pix_check <= 1'b1;
        run_frame();
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout after %0d frames, the test did not finish", FRAMES_TESTED + FRAME_MARGIN);
        abort_run();
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------

    initial begin : main
        int       i;
        reg_sel_e sel;
        wb_data_t val;
        wb_data_t got;
        seed = 18;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // random write and read-back, pixels unchecked while registers churn
        for (i = 0; i < 25; i++) begin
            sel = reg_sel_e'(3'(i % 5));
            val = wb_data_t'($random(seed));
            wb_write(sel, val);
            wb_read(sel, got);
            check_wb_data(got, read_mask(sel, val), sel);
        end
        wb_read(REG_RAM_DATA, got);
        check_wb_data(got, '0, REG_RAM_DATA);
        wb_read(3'd7, got);
        check_wb_data(got, '0, 3'd7);

        // every pattern with the sprite off
        for (i = 0; i < 4; i++) begin
            frame_step(0, 0, 1'b0, pattern_e'(2'(i)), rgb_t'(12'($random(seed))));
        end

        // sprite fully on screen
        load_sprite();
        for (i = 0; i < 3; i++) begin
            frame_step(rand_below(H_DISPLAY - SPR_W + 1), rand_below(V_DISPLAY - SPR_H + 1),
                       1'b1, pattern_e'(2'(rand_below(4))), rgb_t'(12'($random(seed))));
        end

        // clipped at the right edge, the bottom edge, negative origin, corner
        frame_step(H_DISPLAY - 14 + rand_below(14), rand_below(V_DISPLAY - SPR_H + 1),
                   1'b1, PAT_CHECKER, rgb_t'(0));
        frame_step(rand_below(H_DISPLAY - SPR_W + 1), V_DISPLAY - 14 + rand_below(14),
                   1'b1, PAT_VBARS, rgb_t'(0));
        frame_step(-1 - rand_below(15), -1 - rand_below(15),
                   1'b1, PAT_SOLID, rgb_t'(12'($random(seed))));
        frame_step(H_DISPLAY - 14 + rand_below(14), V_DISPLAY - 14 + rand_below(14),
                   1'b1, PAT_HBARS, rgb_t'(0));

        // sprite off again, plain background
        frame_step(int'($signed(sh_x0)), int'($signed(sh_y0)), 1'b0, sh_pat, sh_bg);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: include/vga.svh
/*
 * raster coordinate widths shared by the pixel stages
 * H_SIZE covers x, V_SIZE covers y
 */
`ifndef VGA_SVH
`define VGA_SVH

// horizontal counter width, up to 2048 clocks per line
`define H_SIZE 11

// vertical counter width, up to 1024 lines per frame
`define V_SIZE 10

`endif

// File: rtl/video_bar_gen.sv
/*
 * background pattern stage, pipeline stage 1
 * solid colour, horizontal bars, vertical bars and checkerboard
 */
`default_nettype none

`include "vga.svh"

module video_bar_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  video_pkg::pattern_e pattern,
    input  video_pkg::rgb_t     bg_color,
    input  logic [`H_SIZE-1:0]  xx_i,
    input  logic [`V_SIZE-1:0]  yy_i,
    input  logic                hsync_i,
    input  logic                vsync_i,
    input  logic                video_on_i,
    output logic [`H_SIZE-1:0]  xx,
    output logic [`V_SIZE-1:0]  yy,
    output logic                hsync,
    output logic                vsync,
    output logic                video_on,
    output video_pkg::rgb_t     src_rgb
);

    import video_pkg::*;

    rgb_t bg_next;

    // pattern colour from the incoming coordinates
    always_comb begin
        case (pattern)
            PAT_SOLID:   bg_next = bg_color;
            // grey ramp, 16 levels over 64 lines
            PAT_HBARS:   bg_next = '{r: yy_i[5:2], g: yy_i[5:2], b: yy_i[5:2]};
            PAT_VBARS:   bg_next = '{r: xx_i[5:2], g: xx_i[5:2], b: xx_i[5:2]};
            // 8x8 squares
            PAT_CHECKER: bg_next = (xx_i[3] ^ yy_i[3]) ? '1 : '0;
            default:     bg_next = bg_color;
        endcase
    end

    // ----------------------------------------
    // stage register
    // ----------------------------------------

    // sync and blanking flags reset to the blanked state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync    <= 1'b1;
            vsync    <= 1'b1;
            video_on <= 1'b0;
        end else begin
            hsync    <= hsync_i;
            vsync    <= vsync_i;
            video_on <= video_on_i;
        end
    end

    // pixel payload
    always_ff @(posedge clk) begin
        xx      <= xx_i;
        yy      <= yy_i;
        src_rgb <= bg_next;
    end

endmodule

`default_nettype wire

// File: rtl/video_overlay_top.sv
/*
 * video overlay top level
 * wishbone register slave, sync, background and sprite stages
 */
`default_nettype none

`include "vga.svh"

module video_overlay_top #(
    parameter int              H_DISPLAY     = 64,
    parameter int              H_FRONT       = 4,
    parameter int              H_SYNC        = 8,
    parameter int              H_BACK        = 4,
    parameter int              V_DISPLAY     = 48,
    parameter int              V_FRONT       = 2,
    parameter int              V_SYNC        = 2,
    parameter int              V_BACK        = 2,
    parameter int              SPRITE_HSIZE  = 16,
    parameter int              SPRITE_VSIZE  = 16,
    parameter int              SPRITE_RAM_AW = 8,
    parameter video_pkg::rgb_t KEY_COLOR     = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  video_pkg::wb_addr_t wb_adr,
    input  video_pkg::wb_data_t wb_dat_i,
    output video_pkg::wb_data_t wb_dat_o,
    output logic                wb_ack,
    output logic                hsync,
    output logic                vsync,
    output video_pkg::rgb_t     rgb
);

    import video_pkg::*;

    // register outputs
    wb_data_t                 x0;
    wb_data_t                 y0;
    logic                     sprite_en;
    pattern_e                 pattern;
    rgb_t                     bg_color;
    logic                     ram_we;
    logic [SPRITE_RAM_AW-1:0] ram_addr_w;
    rgb_t                     ram_din;

    // stage 0 to stage 1
    logic [`H_SIZE-1:0] s0_xx;
    logic [`V_SIZE-1:0] s0_yy;
    logic               s0_hsync;
    logic               s0_vsync;
    logic               s0_video_on;

    // stage 1 to stage 2
    logic [`H_SIZE-1:0] s1_xx;
    logic [`V_SIZE-1:0] s1_yy;
    logic               s1_hsync;
    logic               s1_vsync;
    logic               s1_video_on;
    rgb_t               s1_rgb;

    video_wb_regs #(
        .SPRITE_RAM_AW (SPRITE_RAM_AW)
    ) u_wb_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .x0         (x0),
        .y0         (y0),
        .sprite_en  (sprite_en),
        .pattern    (pattern),
        .bg_color   (bg_color),
        .ram_we     (ram_we),
        .ram_addr_w (ram_addr_w),
        .ram_din    (ram_din)
    );

    // ----------------------------------------
    // pixel pipeline, three cycles deep
    // ----------------------------------------

    video_sync_gen #(
        .H_DISPLAY (H_DISPLAY),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_DISPLAY (V_DISPLAY),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) u_sync_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .xx       (s0_xx),
        .yy       (s0_yy),
        .hsync    (s0_hsync),
        .vsync    (s0_vsync),
        .video_on (s0_video_on)
    );

    video_bar_gen u_bar_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .pattern    (pattern),
        .bg_color   (bg_color),
        .xx_i       (s0_xx),
        .yy_i       (s0_yy),
        .hsync_i    (s0_hsync),
        .vsync_i    (s0_vsync),
        .video_on_i (s0_video_on),
        .xx         (s1_xx),
        .yy         (s1_yy),
        .hsync      (s1_hsync),
        .vsync      (s1_vsync),
        .video_on   (s1_video_on),
        .src_rgb    (s1_rgb)
    );

    video_sprite_gen #(
        .SPRITE_HSIZE  (SPRITE_HSIZE),
        .SPRITE_VSIZE  (SPRITE_VSIZE),
        .SPRITE_RAM_AW (SPRITE_RAM_AW),
        .KEY_COLOR     (KEY_COLOR)
    ) u_sprite_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .x0         (x0),
        .y0         (y0),
        .sprite_en  (sprite_en),
        .ram_we     (ram_we),
        .ram_addr_w (ram_addr_w),
        .ram_din    (ram_din),
        .xx         (s1_xx),
        .yy         (s1_yy),
        .hsync_i    (s1_hsync),
        .vsync_i    (s1_vsync),
        .video_on_i (s1_video_on),
        .src_rgb    (s1_rgb),
        .hsync      (hsync),
        .vsync      (vsync),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

// File: rtl/video_pkg.sv
/*
 * shared types of the video overlay subsystem
 * pixel colour, wishbone address and data words
 * register map and background pattern enums
 */
`default_nettype none

package video_pkg;

    // ----------------------------------------
    // pixel colour
    // ----------------------------------------

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // ----------------------------------------
    // wishbone bus
    // ----------------------------------------

    // word address, one register per word
    typedef logic [2:0]  wb_addr_t;
    typedef logic [15:0] wb_data_t;

    // register map
    typedef enum wb_addr_t {
        REG_X0       = 3'd0,
        REG_Y0       = 3'd1,
        REG_CTRL     = 3'd2,
        REG_BG       = 3'd3,
        REG_RAM_ADDR = 3'd4,
        REG_RAM_DATA = 3'd5
    } reg_sel_e;

    // background test patterns, held in ctrl bits 2:1
    typedef enum logic [1:0] {
        PAT_SOLID   = 2'd0,
        PAT_HBARS   = 2'd1,
        PAT_VBARS   = 2'd2,
        PAT_CHECKER = 2'd3
    } pattern_e;

endpackage

`default_nettype wire

// File: rtl/video_sprite_gen.sv
/*
 * sprite overlay stage, pipeline stage 2
 * region test, sprite memory address mapping
 * chroma-key blend and output register
 */
`default_nettype none

`include "vga.svh"

module video_sprite_gen #(
    parameter int              SPRITE_HSIZE  = 16,
    parameter int              SPRITE_VSIZE  = 16,
    parameter int              SPRITE_RAM_AW = 8,
    parameter video_pkg::rgb_t KEY_COLOR     = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  video_pkg::wb_data_t      x0,
    input  video_pkg::wb_data_t      y0,
    input  logic                     sprite_en,
    input  logic                     ram_we,
    input  logic [SPRITE_RAM_AW-1:0] ram_addr_w,
    input  video_pkg::rgb_t          ram_din,
    input  logic [`H_SIZE-1:0]       xx,
    input  logic [`V_SIZE-1:0]       yy,
    input  logic                     hsync_i,
    input  logic                     vsync_i,
    input  logic                     video_on_i,
    input  video_pkg::rgb_t          src_rgb,
    output logic                     hsync,
    output logic                     vsync,
    output video_pkg::rgb_t          rgb
);

    import video_pkg::*;

    // one bit above the 16-bit origin so the difference never wraps
    localparam int CW      = 17;
    localparam int X_SHIFT = $clog2(SPRITE_HSIZE);
    localparam logic signed [CW-1:0] X_LIM = CW'(SPRITE_HSIZE);
    localparam logic signed [CW-1:0] Y_LIM = CW'(SPRITE_VSIZE);

    logic signed [CW-1:0]     dx;
    logic signed [CW-1:0]     dy;
    logic                     in_region;
    logic [SPRITE_RAM_AW-1:0] addr_r;
    rgb_t                     ram_dout;

    logic region_d;
    logic hsync_d;
    logic vsync_d;
    logic video_on_d;
    rgb_t src_d;
    logic show_sprite;

    // ----------------------------------------
    // region test and address mapping
    // ----------------------------------------

    // screen coordinates relative to the sprite origin, origin may be negative
    assign dx = $signed(CW'(xx)) - CW'($signed(x0));
    assign dy = $signed(CW'(yy)) - CW'($signed(y0));

    assign in_region = (dx >= 0) && (dx < X_LIM) && (dy >= 0) && (dy < Y_LIM);

    // row-major, row length is a power of two so the multiply is a shift
    assign addr_r = SPRITE_RAM_AW'(dx) + SPRITE_RAM_AW'(dy << X_SHIFT);

    video_sprite_ram #(
        .AW (SPRITE_RAM_AW),
        .DW ($bits(rgb_t))
    ) u_sprite_ram (
        .clk    (clk),
        .we     (ram_we),
        .addr_w (ram_addr_w),
        .addr_r (addr_r),
        .din    (ram_din),
        .dout   (ram_dout)
    );

    // ----------------------------------------
    // delay register, matches the memory read
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync_d    <= 1'b1;
            vsync_d    <= 1'b1;
            video_on_d <= 1'b0;
        end else begin
            hsync_d    <= hsync_i;
            vsync_d    <= vsync_i;
            video_on_d <= video_on_i;
        end
    end

    always_ff @(posedge clk) begin
        region_d <= in_region;
        src_d    <= src_rgb;
    end

    // key colour lets the background show through
    assign show_sprite = sprite_en && region_d && (ram_dout != KEY_COLOR);

    // output register, black during blanking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            rgb   <= '0;
        end else begin
            hsync <= hsync_d;
            vsync <= vsync_d;
            if (!video_on_d) begin
                rgb <= '0;
            end else if (show_sprite) begin
                rgb <= ram_dout;
            end else begin
                rgb <= src_d;
            end
        end
    end

    // whole sprite must fit the memory
    a_ram_fits: assert property (@(posedge clk) disable iff (!rst_n)
        SPRITE_HSIZE * SPRITE_VSIZE <= 2 ** SPRITE_RAM_AW)
        else $error("sprite of %0dx%0d does not fit the memory", SPRITE_HSIZE, SPRITE_VSIZE);

endmodule

`default_nettype wire

// File: rtl/video_sprite_ram.sv
/*
 * simple dual-port sprite memory
 * synchronous write, registered read, maps to block ram
 */
`default_nettype none

module video_sprite_ram #(
    parameter int AW = 8,
    parameter int DW = 12
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] addr_w,
    input  logic [AW-1:0] addr_r,
    input  logic [DW-1:0] din,
    output logic [DW-1:0] dout
);

    logic [DW-1:0] mem [2**AW];

    // write port, loaded from the bus side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr_w] <= din;
        end
    end

    // read port, one cycle of latency
    always_ff @(posedge clk) begin
        dout <= mem[addr_r];
    end

endmodule

`default_nettype wire

// File: rtl/video_sync_gen.sv
/*
 * raster scan generator, pipeline stage 0
 * horizontal and vertical counters, sync pulses, display-active flag
 */
`default_nettype none

`include "vga.svh"

module video_sync_gen #(
    parameter int H_DISPLAY = 64,
    parameter int H_FRONT   = 4,
    parameter int H_SYNC    = 8,
    parameter int H_BACK    = 4,
    parameter int V_DISPLAY = 48,
    parameter int V_FRONT   = 2,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic [`H_SIZE-1:0] xx,
    output logic [`V_SIZE-1:0] yy,
    output logic               hsync,
    output logic               vsync,
    output logic               video_on
);

    // ----------------------------------------
    // raster constants at counter width
    // ----------------------------------------

    localparam logic [`H_SIZE-1:0] H_LAST   = `H_SIZE'(H_DISPLAY + H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [`H_SIZE-1:0] H_SS     = `H_SIZE'(H_DISPLAY + H_FRONT);
    localparam logic [`H_SIZE-1:0] H_SE     = `H_SIZE'(H_DISPLAY + H_FRONT + H_SYNC - 1);
    localparam logic [`H_SIZE-1:0] H_ACTIVE = `H_SIZE'(H_DISPLAY);

    localparam logic [`V_SIZE-1:0] V_LAST   = `V_SIZE'(V_DISPLAY + V_FRONT + V_SYNC + V_BACK - 1);
    localparam logic [`V_SIZE-1:0] V_SS     = `V_SIZE'(V_DISPLAY + V_FRONT);
    localparam logic [`V_SIZE-1:0] V_SE     = `V_SIZE'(V_DISPLAY + V_FRONT + V_SYNC - 1);
    localparam logic [`V_SIZE-1:0] V_ACTIVE = `V_SIZE'(V_DISPLAY);

    logic               h_wrap;
    logic [`H_SIZE-1:0] h_next;
    logic [`V_SIZE-1:0] v_next;

    // ----------------------------------------
    // next counter values
    // ----------------------------------------

    // vertical counter steps once per horizontal wrap
    always_comb begin
        h_wrap = (xx == H_LAST);
        h_next = h_wrap ? '0 : xx + 1'b1;
        v_next = yy;
        if (h_wrap) begin
            v_next = (yy == V_LAST) ? '0 : yy + 1'b1;
        end
    end

    // syncs and video_on decode the next count so they line up with xx/yy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xx       <= '0;
            yy       <= '0;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
            // origin is inside the visible area
            video_on <= 1'b1;
        end else begin
            xx       <= h_next;
            yy       <= v_next;
            hsync    <= !((h_next >= H_SS) && (h_next <= H_SE));
            vsync    <= !((v_next >= V_SS) && (v_next <= V_SE));
            video_on <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
        end
    end

    // counters never leave the raster
    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        (xx <= H_LAST) && (yy <= V_LAST))
        else $error("raster counter out of range x=%0d y=%0d", xx, yy);

endmodule

`default_nettype wire

// File: rtl/video_wb_regs.sv
/*
 * wishbone classic slave
 * origin, control and background registers
 * sprite load port with auto-increment
 */
`default_nettype none

module video_wb_regs #(
    parameter int SPRITE_RAM_AW = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  video_pkg::wb_addr_t      wb_adr,
    input  video_pkg::wb_data_t      wb_dat_i,
    output video_pkg::wb_data_t      wb_dat_o,
    output logic                     wb_ack,
    output video_pkg::wb_data_t      x0,
    output video_pkg::wb_data_t      y0,
    output logic                     sprite_en,
    output video_pkg::pattern_e      pattern,
    output video_pkg::rgb_t          bg_color,
    output logic                     ram_we,
    output logic [SPRITE_RAM_AW-1:0] ram_addr_w,
    output video_pkg::rgb_t          ram_din
);

    import video_pkg::*;

    logic                     req;
    logic                     ram_wr;
    reg_sel_e                 sel;
    logic [SPRITE_RAM_AW-1:0] ld_addr;
    wb_data_t                 rd_mux;

    // new request, ack goes high on the next edge
    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign sel    = reg_sel_e'(wb_adr);
    assign ram_wr = req && wb_we && (sel == REG_RAM_DATA);

    // ----------------------------------------
    // read multiplexer
    // ----------------------------------------

    // unused bits and the data port read as zero
    always_comb begin
        case (sel)
            REG_X0:       rd_mux = x0;
            REG_Y0:       rd_mux = y0;
            REG_CTRL:     rd_mux = {13'b0, pattern, sprite_en};
            REG_BG:       rd_mux = {4'b0, bg_color};
            REG_RAM_ADDR: rd_mux = wb_data_t'(ld_addr);
            default:      rd_mux = '0;
        endcase
    end

    // ----------------------------------------
    // register file and ack
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            x0        <= '0;
            y0        <= '0;
            sprite_en <= 1'b0;
            pattern   <= PAT_SOLID;
            bg_color  <= '0;
            ld_addr   <= '0;
            ram_we    <= 1'b0;
        end else begin
            wb_ack <= req;
            ram_we <= ram_wr;
            // writes land on the same edge that raises ack
            if (req && wb_we) begin
                case (sel)
                    REG_X0:       x0 <= wb_dat_i;
                    REG_Y0:       y0 <= wb_dat_i;
                    REG_CTRL: begin
                        sprite_en <= wb_dat_i[0];
                        pattern   <= pattern_e'(wb_dat_i[2:1]);
                    end
                    REG_BG:       bg_color <= rgb_t'(wb_dat_i[11:0]);
                    REG_RAM_ADDR: ld_addr <= wb_dat_i[SPRITE_RAM_AW-1:0];
                    // store happens next cycle at the captured address
                    REG_RAM_DATA: ld_addr <= ld_addr + 1'b1;
                    default:      ;
                endcase
            end
        end
    end

    // read data and memory write payload
    always_ff @(posedge clk) begin
        wb_dat_o <= (req && !wb_we) ? rd_mux : '0;
        if (ram_wr) begin
            ram_addr_w <= ld_addr;
            ram_din    <= rgb_t'(wb_dat_i[11:0]);
        end
    end

    // ack only answers an open request
    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack without cyc and stb");

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
rtl/video_pkg.sv
rtl/video_sync_gen.sv
rtl/video_bar_gen.sv
rtl/video_sprite_ram.sv
rtl/video_sprite_gen.sv
rtl/video_wb_regs.sv
rtl/video_overlay_top.sv
dv/video_tb.sv
